// ==== hw/rv_branch_pkg.sv ====
////////////////////////////////////////
// Branch slice shared definitions
// Opcodes, funct3 codes, instruction layouts, counters
////////////////////////////////////////

package rv_branch_pkg;

  ////////////////////////////////////////
  // Major opcodes, instr[6:2]
  ////////////////////////////////////////
  localparam logic [4:0] opc_branch  = 5'b11000;
  localparam logic [4:0] opc_jal     = 5'b11011;
  localparam logic [4:0] opc_jalr    = 5'b11001;
  localparam logic [4:0] opc_miscmem = 5'b00011;

  // Branch conditions in funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // FENCE.I with rd, rs1 and imm all zero
  localparam logic [31:0] instr_fence_i = 32'h0000_100f;

  // Exception vector
  localparam int exc_size               = 16;
  localparam int cause_misaligned_instr = 0;

  ////////////////////////////////////////
  // Instruction layouts
  ////////////////////////////////////////

  // B-type, immediate scattered around rs fields
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // J-type, 20 bit offset for JAL
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // Same word, read as either layout or raw
  typedef union packed {
    b_fmt_t      b;
    j_fmt_t      j;
    logic [31:0] raw;
  } rv_instr_u;

  ////////////////////////////////////////
  // Two-bit predictor counters
  ////////////////////////////////////////
  localparam logic [1:0] ctr_strong_nt = 2'b00;
  localparam logic [1:0] ctr_weak_nt   = 2'b01;
  localparam logic [1:0] ctr_strong_t  = 2'b11;

endpackage

// ==== hw/rv_branch_predictor.sv ====
////////////////////////////////////////
// Branch predictor
// Global history XOR PC into two-bit counters
////////////////////////////////////////

`timescale 1ns/1ns

module rv_branch_predictor #(
  parameter int xlen           = 32,
  parameter int bp_global_bits = 2,
  parameter int bht_idx_bits   = 6
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            ex_stall,
  input  logic [xlen-1:0] id_pc,
  input  logic            bu_bp_update,
  input  logic            bu_bp_btaken,
  output logic [1:0]      id_bp_predict
);

  import rv_branch_pkg::*;

  localparam int bht_depth = 1 << bht_idx_bits;

  logic [1:0]                bht [bht_depth];
  logic [bp_global_bits-1:0] history;
  logic [bp_global_bits:0]   history_shift;
  logic [bht_idx_bits-1:0]   lookup_idx;
  logic [bht_idx_bits-1:0]   update_idx;
  logic [1:0]                upd_ctr;

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////

  // Word index of the PC, history zero-extended on top
  assign lookup_idx = id_pc[bht_idx_bits+1:2] ^
                      {{(bht_idx_bits-bp_global_bits){1'b0}}, history};

  assign id_bp_predict = bht[lookup_idx];

  // Resolution comes a cycle later, keep the index for it
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      update_idx <= '0;
    end else if (!ex_stall) begin
      update_idx <= lookup_idx;
    end
  end

  ////////////////////////////////////////
  // Update
  ////////////////////////////////////////
  assign upd_ctr = bht[update_idx];

  // Newest outcome enters at bit 0
  assign history_shift = {history, bu_bp_btaken};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      history <= '0;
    end else if (bu_bp_update) begin
      history <= history_shift[bp_global_bits-1:0];
    end
  end

  // Saturating counters, all weakly not-taken out of reset
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < bht_depth; i++) begin
        bht[i] <= ctr_weak_nt;
      end
    end else if (bu_bp_update) begin
      if (bu_bp_btaken && upd_ctr != ctr_strong_t) begin
        bht[update_idx] <= upd_ctr + 2'd1;
      end else if (!bu_bp_btaken && upd_ctr != ctr_strong_nt) begin
        bht[update_idx] <= upd_ctr - 2'd1;
      end
    end
  end

  // Table and history fully reset, prediction must be defined
  a_predict_known : assert property (
    @(posedge clk) disable iff (!rstn) !$isunknown(id_bp_predict));

endmodule

// ==== hw/rv_branch_unit.sv ====
////////////////////////////////////////
// Branch unit
// Resolves jumps and branches, next PC, flushes
////////////////////////////////////////

`timescale 1ns/1ns

module rv_branch_unit #(
  parameter int              xlen           = 32,
  parameter logic [xlen-1:0] pc_init        = 'h200,
  parameter int              bp_global_bits = 2,
  parameter int              has_rvc        = 1
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              ex_stall,
  input  logic                              st_flush,
  input  logic                              pipe_exception,
  input  logic [xlen-1:0]                   id_pc,
  input  rv_branch_pkg::rv_instr_u          id_instr,
  input  logic                              id_bubble,
  input  logic [xlen-1:0]                   op_a,
  input  logic [xlen-1:0]                   op_b,
  input  logic [rv_branch_pkg::exc_size-1:0] id_exception,
  input  logic [1:0]                        id_bp_predict,
  input  logic                              du_stall,
  input  logic                              du_we_pc,
  input  logic [xlen-1:0]                   du_dato,
  output logic [xlen-1:0]                   bu_nxt_pc,
  output logic                              bu_flush,
  output logic                              bu_cacheflush,
  output logic [rv_branch_pkg::exc_size-1:0] bu_exception,
  output logic [1:0]                        bu_bp_predict,
  output logic                              bu_bp_btaken,
  output logic                              bu_bp_update
);

  import rv_branch_pkg::*;

  localparam logic [xlen-1:0] pc_step = 4;

  logic [4:0]      opcode;
  logic [2:0]      funct3;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_b;
  // Compare results
  logic            op_eq;
  logic            op_lt_s;
  logic            op_lt_u;
  logic            cond_taken;
  logic            cond_valid;
  // Resolved controls
  logic            btaken;
  logic            bp_update;
  logic            pipeflush;
  logic            cacheflush;
  logic [xlen-1:0] nxt_pc;
  logic            chk_align;
  logic            misaligned;
  // Debug override
  logic [xlen-1:0] du_nxt_pc;
  logic            du_we_pc_dly;
  logic            du_wrote_pc;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////
  assign opcode = id_instr.raw[6:2];
  assign funct3 = id_instr.b.funct3;

  // Both offsets from the same word
  assign imm_j = {{(xlen-20){id_instr.j.imm20}}, id_instr.j.imm19_12,
                  id_instr.j.imm11, id_instr.j.imm10_1, 1'b0};
  assign imm_b = {{(xlen-12){id_instr.b.imm12}}, id_instr.b.imm11,
                  id_instr.b.imm10_5, id_instr.b.imm4_1, 1'b0};

  assign op_eq   = (op_a == op_b);
  assign op_lt_s = ($signed(op_a) < $signed(op_b));
  assign op_lt_u = (op_a < op_b);

  // Branch condition by funct3
  always_comb begin
    cond_valid = 1'b1;
    case (funct3)
      f3_beq:  cond_taken = op_eq;
      f3_bne:  cond_taken = ~op_eq;
      f3_blt:  cond_taken = op_lt_s;
      f3_bge:  cond_taken = ~op_lt_s;
      f3_bltu: cond_taken = op_lt_u;
      f3_bgeu: cond_taken = ~op_lt_u;
      default: begin
        // 010 and 011 are not branches
        cond_taken = 1'b0;
        cond_valid = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Resolution
  ////////////////////////////////////////
  always_comb begin
    btaken     = 1'b0;
    bp_update  = 1'b0;
    pipeflush  = 1'b0;
    cacheflush = 1'b0;
    nxt_pc     = id_pc + pc_step;
    if (!id_bubble) begin
      case (opcode)
        // Fetch already redirected so only the NPC matters for debug
        opc_jal: begin
          btaken = 1'b1;
          nxt_pc = id_pc + imm_j;
        end
        opc_jalr: begin
          btaken    = 1'b1;
          pipeflush = 1'b1;
          nxt_pc    = (op_a + op_b) & ~{{(xlen-1){1'b0}}, 1'b1};
        end
        opc_branch: begin
          if (cond_valid) begin
            btaken    = cond_taken;
            bp_update = 1'b1;
            // Mispredict against counter MSB
            pipeflush = cond_taken ^ id_bp_predict[1];
            if (cond_taken) begin
              nxt_pc = id_pc + imm_b;
            end
          end
        end
        opc_miscmem: begin
          if (id_instr.raw == instr_fence_i) begin
            pipeflush  = 1'b1;
            cacheflush = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // Alignment rule depends on compressed support
  assign chk_align  = ~id_bubble & ((opcode == opc_jalr) | (opcode == opc_branch));
  assign misaligned = (has_rvc != 0) ? nxt_pc[0] : |nxt_pc[1:0];

  // Exception register frozen by ex_stall
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bu_exception <= '0;
    end else if (!ex_stall) begin
      if (bu_flush || st_flush || pipe_exception) begin
        bu_exception <= '0;
      end else begin
        bu_exception <= id_exception;
        bu_exception[cause_misaligned_instr] <=
          id_exception[cause_misaligned_instr] | (chk_align & misaligned);
      end
    end
  end

  ////////////////////////////////////////
  // Debug PC override
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (du_we_pc) begin
      du_nxt_pc <= du_dato;
    end
  end

  // Override stays active while the debugger holds the stall
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      du_we_pc_dly <= 1'b0;
      du_wrote_pc  <= 1'b0;
    end else begin
      du_we_pc_dly <= du_we_pc;
      du_wrote_pc  <= du_we_pc | (du_wrote_pc & du_stall);
    end
  end

  // Registered outputs
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bu_flush      <= 1'b1;
      bu_cacheflush <= 1'b0;
      bu_nxt_pc     <= pc_init;
      bu_bp_predict <= 2'b00;
      bu_bp_btaken  <= 1'b0;
      bu_bp_update  <= 1'b0;
    end else if (du_wrote_pc) begin
      // Flush only on the first cycle of the override
      bu_flush      <= du_we_pc_dly;
      bu_cacheflush <= 1'b0;
      bu_nxt_pc     <= du_nxt_pc;
      bu_bp_predict <= 2'b00;
      bu_bp_btaken  <= 1'b0;
      bu_bp_update  <= 1'b0;
    end else begin
      bu_flush      <= pipeflush & ~du_stall;
      bu_cacheflush <= cacheflush & ~du_stall;
      bu_nxt_pc     <= nxt_pc;
      bu_bp_predict <= id_bp_predict;
      bu_bp_btaken  <= btaken;
      bu_bp_update  <= bp_update;
    end
  end

  // Cache flush always comes with a pipeline flush
  a_cacheflush_flush : assert property (
    @(posedge clk) disable iff (!rstn) bu_cacheflush |-> bu_flush);

  // Debug PC out two clocks after the write pulse with flush and no training
  a_override_no_update : assert property (
    @(posedge clk) disable iff (!rstn)
    $past(du_we_pc, 2) |->
      (bu_flush && !bu_bp_update && bu_nxt_pc == $past(du_dato, 2)));

endmodule

// ==== hw/rv_branch_dbg_wb.sv ====
////////////////////////////////////////
// Debug Wishbone slave
// Stall control, next PC access, mispredict count
////////////////////////////////////////

`timescale 1ns/1ns

module rv_branch_dbg_wb #(
  parameter int xlen = 32
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            wb_cyc,
  input  logic            wb_stb,
  input  logic            wb_we,
  input  logic [1:0]      wb_adr,
  input  logic [xlen-1:0] wb_dat_i,
  input  logic [xlen-1:0] bu_nxt_pc,
  input  logic            bu_bp_update,
  input  logic            bu_bp_btaken,
  input  logic [1:0]      bu_bp_predict,
  output logic [xlen-1:0] wb_dat_o,
  output logic            wb_ack,
  output logic            du_stall,
  output logic            du_we_pc,
  output logic [xlen-1:0] du_dato
);

  logic        req;
  logic        wr;
  logic        mispredict;
  logic [15:0] miss_cnt;

  // New request only when no ack pending
  assign req = wb_cyc & wb_stb & ~wb_ack;
  assign wr  = req & wb_we;

  ////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wb_ack   <= 1'b0;
      du_stall <= 1'b0;
      du_we_pc <= 1'b0;
    end else begin
      wb_ack   <= req;
      du_we_pc <= wr & (wb_adr == 2'd0);
      // Control word, bit 0 only
      if (wr && wb_adr == 2'd1) begin
        du_stall <= wb_dat_i[0];
      end
    end
  end

  // PC data for the branch unit
  always_ff @(posedge clk) begin
    if (wr && wb_adr == 2'd0) begin
      du_dato <= wb_dat_i;
    end
  end

  // Read data valid with ack
  always_ff @(posedge clk) begin
    if (req && !wb_we) begin
      case (wb_adr)
        2'd0:    wb_dat_o <= bu_nxt_pc;
        2'd1:    wb_dat_o <= {{(xlen-1){1'b0}}, du_stall};
        2'd2:    wb_dat_o <= {{(xlen-16){1'b0}}, miss_cnt};
        default: wb_dat_o <= '0;
      endcase
    end
  end

  ////////////////////////////////////////
  // Mispredict counter
  ////////////////////////////////////////
  assign mispredict = bu_bp_update & (bu_bp_btaken ^ bu_bp_predict[1]);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      miss_cnt <= '0;
    end else if (mispredict && miss_cnt != 16'hffff) begin
      miss_cnt <= miss_cnt + 16'd1;
    end
  end

  // Single-cycle ack per transfer
  a_ack_one_cycle : assert property (
    @(posedge clk) disable iff (!rstn) wb_ack |=> !wb_ack);

endmodule

// ==== hw/rv_branch_top.sv ====
////////////////////////////////////////
// Branch slice top
// Predictor, branch unit and debug slave
////////////////////////////////////////

`timescale 1ns/1ns

module rv_branch_top #(
  parameter int              xlen           = 32,
  parameter logic [xlen-1:0] pc_init        = 'h200,
  parameter int              bp_global_bits = 2,
  parameter int              bht_idx_bits   = 6,
  parameter int              has_rvc        = 1
) (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic [xlen-1:0]                    id_pc,
  input  logic [31:0]                        id_instr,
  input  logic                               id_bubble,
  input  logic [xlen-1:0]                    op_a,
  input  logic [xlen-1:0]                    op_b,
  input  logic [rv_branch_pkg::exc_size-1:0] id_exception,
  input  logic                               pipe_exception,
  input  logic                               ex_stall,
  input  logic                               st_flush,
  output logic [xlen-1:0]                    bu_nxt_pc,
  output logic                               bu_flush,
  output logic                               bu_cacheflush,
  output logic [rv_branch_pkg::exc_size-1:0] bu_exception,
  output logic [1:0]                         bu_bp_predict,
  output logic                               bu_bp_btaken,
  // Debug Wishbone
  input  logic                               wb_cyc,
  input  logic                               wb_stb,
  input  logic                               wb_we,
  input  logic [1:0]                         wb_adr,
  input  logic [xlen-1:0]                    wb_dat_i,
  output logic [xlen-1:0]                    wb_dat_o,
  output logic                               wb_ack
);

  logic [1:0]      id_bp_predict;
  logic            bu_bp_update;
  // Debug to branch unit
  logic            du_stall;
  logic            du_we_pc;
  logic [xlen-1:0] du_dato;

  rv_branch_predictor #(
    .xlen           (xlen),
    .bp_global_bits (bp_global_bits),
    .bht_idx_bits   (bht_idx_bits)
  ) u_predictor (
    .clk           (clk),
    .rstn          (rstn),
    .ex_stall      (ex_stall),
    .id_pc         (id_pc),
    .bu_bp_update  (bu_bp_update),
    .bu_bp_btaken  (bu_bp_btaken),
    .id_bp_predict (id_bp_predict)
  );

  rv_branch_unit #(
    .xlen           (xlen),
    .pc_init        (pc_init),
    .bp_global_bits (bp_global_bits),
    .has_rvc        (has_rvc)
  ) u_branch_unit (
    .clk            (clk),
    .rstn           (rstn),
    .ex_stall       (ex_stall),
    .st_flush       (st_flush),
    .pipe_exception (pipe_exception),
    .id_pc          (id_pc),
    .id_instr       (id_instr),
    .id_bubble      (id_bubble),
    .op_a           (op_a),
    .op_b           (op_b),
    .id_exception   (id_exception),
    .id_bp_predict  (id_bp_predict),
    .du_stall       (du_stall),
    .du_we_pc       (du_we_pc),
    .du_dato        (du_dato),
    .bu_nxt_pc      (bu_nxt_pc),
    .bu_flush       (bu_flush),
    .bu_cacheflush  (bu_cacheflush),
    .bu_exception   (bu_exception),
    .bu_bp_predict  (bu_bp_predict),
    .bu_bp_btaken   (bu_bp_btaken),
    .bu_bp_update   (bu_bp_update)
  );

  rv_branch_dbg_wb #(
    .xlen (xlen)
  ) u_dbg_wb (
    .clk           (clk),
    .rstn          (rstn),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_i      (wb_dat_i),
    .bu_nxt_pc     (bu_nxt_pc),
    .bu_bp_update  (bu_bp_update),
    .bu_bp_btaken  (bu_bp_btaken),
    .bu_bp_predict (bu_bp_predict),
    .wb_dat_o      (wb_dat_o),
    .wb_ack        (wb_ack),
    .du_stall      (du_stall),
    .du_we_pc      (du_we_pc),
    .du_dato       (du_dato)
  );

endmodule

// ==== bench/rv_branch_tb.sv ====
////////////////////////////////////////
// Branch slice testbench
// Directed tests against a reference model
////////////////////////////////////////

`timescale 1ns/1ns

module rv_branch_tb;

  import rv_branch_pkg::*;

  localparam int              xlen           = 32;
  localparam logic [xlen-1:0] pc_init        = 32'h200;
  localparam int              bp_global_bits = 2;
  localparam int              bht_idx_bits   = 6;
  localparam int              has_rvc        = 1;
  localparam int              wb_timeout     = 16;
  localparam int              pc_timeout     = 16;

  logic                clk;
  logic                rstn;
  logic [xlen-1:0]     id_pc;
  logic [31:0]         id_instr;
  logic                id_bubble;
  logic [xlen-1:0]     op_a;
  logic [xlen-1:0]     op_b;
  logic [exc_size-1:0] id_exception;
  logic                pipe_exception;
  logic                ex_stall;
  logic                st_flush;
  logic [xlen-1:0]     bu_nxt_pc;
  logic                bu_flush;
  logic                bu_cacheflush;
  logic [exc_size-1:0] bu_exception;
  logic [1:0]          bu_bp_predict;
  logic                bu_bp_btaken;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [1:0]          wb_adr;
  logic [xlen-1:0]     wb_dat_i;
  logic [xlen-1:0]     wb_dat_o;
  logic                wb_ack;

  // Reference predictor state
  logic [1:0]                model_bht [1 << bht_idx_bits];
  logic [bp_global_bits-1:0] model_hist;
  int                        model_miss;
  logic [15:0]               lfsr;

  rv_branch_top #(
    .xlen           (xlen),
    .pc_init        (pc_init),
    .bp_global_bits (bp_global_bits),
    .bht_idx_bits   (bht_idx_bits),
    .has_rvc        (has_rvc)
  ) u_rv_branch_top (
    .clk            (clk),
    .rstn           (rstn),
    .id_pc          (id_pc),
    .id_instr       (id_instr),
    .id_bubble      (id_bubble),
    .op_a           (op_a),
    .op_b           (op_b),
    .id_exception   (id_exception),
    .pipe_exception (pipe_exception),
    .ex_stall       (ex_stall),
    .st_flush       (st_flush),
    .bu_nxt_pc      (bu_nxt_pc),
    .bu_flush       (bu_flush),
    .bu_cacheflush  (bu_cacheflush),
    .bu_exception   (bu_exception),
    .bu_bp_predict  (bu_bp_predict),
    .bu_bp_btaken   (bu_bp_btaken),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack         (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // B-type with x1 and x2 as sources
  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
  endfunction

  function automatic logic [2:0] branch_f3(input int k);
    case (k)
      0:       return f3_beq;
      1:       return f3_bne;
      2:       return f3_blt;
      3:       return f3_bge;
      4:       return f3_bltu;
      default: return f3_bgeu;
    endcase
  endfunction

  task abort_run;
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_pc(input string name, input logic [xlen-1:0] got, exp);
    if (got !== exp) begin
      $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_exc(input string name, input logic [exc_size-1:0] got, exp);
    if (got !== exp) begin
      $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] got, exp);
    if (got !== exp) begin
      $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // One clock, outputs sampled at the falling edge
  task advance_cycle;
    @(posedge clk);
    @(negedge clk);
  endtask

  task idle_cycle;
    id_bubble    = 1'b1;
    id_instr     = 32'h0000_0013;
    id_exception = '0;
    advance_cycle();
  endtask

  // Wishbone classic, held until ack
  task automatic wb_transfer(input logic we, input logic [1:0] adr,
                             input logic [xlen-1:0] wdata, output logic [xlen-1:0] rdata);
    int cycles;
    cycles   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_i = wdata;
    @(negedge clk);
    while (wb_ack !== 1'b1) begin
      if (cycles == wb_timeout) begin
        $display("timeout: no Wishbone ack for word %0d", adr);
        abort_run();
      end
      cycles++;
      @(negedge clk);
    end
    rdata  = wb_dat_o;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  ////////////////////////////////////////
  // Branch with model prediction
  ////////////////////////////////////////
  task automatic run_branch(input logic [2:0] f3, input logic [xlen-1:0] pc, a, b,
                            input logic [12:0] off);
    logic                    taken;
    logic [1:0]              pred;
    logic [bht_idx_bits-1:0] idx;
    logic [xlen-1:0]         exp_pc;
    logic [exc_size-1:0]     exp_exc;
    case (f3)
      f3_beq:  taken = (a == b);
      f3_bne:  taken = (a != b);
      f3_blt:  taken = ($signed(a) < $signed(b));
      f3_bge:  taken = ($signed(a) >= $signed(b));
      f3_bltu: taken = (a < b);
      default: taken = (a >= b);
    endcase
    // Low word bits XOR history
    idx     = pc[bht_idx_bits+1:2] ^ {{(bht_idx_bits-bp_global_bits){1'b0}}, model_hist};
    pred    = model_bht[idx];
    exp_pc  = taken ? pc + {{(xlen-13){off[12]}}, off} : pc + 4;
    exp_exc = '0;
    exp_exc[cause_misaligned_instr] = (has_rvc != 0) ? exp_pc[0] : |exp_pc[1:0];
    id_pc     = pc;
    id_instr  = enc_b(f3, off);
    op_a      = a;
    op_b      = b;
    id_bubble = 1'b0;
    advance_cycle();
    check_flag("bu_bp_btaken", bu_bp_btaken, taken);
    check_pc("bu_nxt_pc", bu_nxt_pc, exp_pc);
    check_flag("bu_flush", bu_flush, taken ^ pred[1]);
    check_flag("bu_bp_predict[1]", bu_bp_predict[1], pred[1]);
    check_flag("bu_bp_predict[0]", bu_bp_predict[0], pred[0]);
    check_exc("bu_exception", bu_exception, exp_exc);
    // Saturating update and history shift
    if (taken && pred != 2'b11) begin
      model_bht[idx] = pred + 2'd1;
    end else if (!taken && pred != 2'b00) begin
      model_bht[idx] = pred - 2'd1;
    end
    model_hist = {model_hist[bp_global_bits-2:0], taken};
    if (taken != pred[1]) begin
      model_miss++;
    end
    // Gap so the table settles before the next lookup
    idle_cycle();
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task test_reset;
    check_flag("bu_flush", bu_flush, 1'b1);
    check_pc("bu_nxt_pc", bu_nxt_pc, pc_init);
    check_flag("bu_cacheflush", bu_cacheflush, 1'b0);
    check_exc("bu_exception", bu_exception, '0);
    check_flag("wb_ack", wb_ack, 1'b0);
  endtask

  task automatic test_branches;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] pc;
    for (int pass = 0; pass < 2; pass++) begin
      for (int k = 0; k < 24; k++) begin
        a  = rand_bits(32);
        b  = rand_bits(32);
        // Equal pair, then both sign orders
        if (k % 4 == 1) begin
          b = a;
        end else if (k % 4 == 2) begin
          a = a | 32'h8000_0000;
          b = b & 32'h7fff_ffff;
        end else if (k % 4 == 3) begin
          a = a & 32'h7fff_ffff;
          b = b | 32'h8000_0000;
        end
        pc = 32'h1000 + (rand_bits(3) << 2);
        run_branch(branch_f3(k / 4), pc, a, b, 13'(rand_bits(12) << 1));
      end
    end
  endtask

  task automatic test_jumps;
    logic [20:0] joff;
    joff      = 21'(rand_bits(20) << 1);
    id_pc     = 32'h0000_3000;
    id_instr  = enc_j(joff);
    id_bubble = 1'b0;
    advance_cycle();
    check_pc("bu_nxt_pc", bu_nxt_pc, 32'h0000_3000 + {{(xlen-21){joff[20]}}, joff});
    check_flag("bu_flush", bu_flush, 1'b0);
    check_exc("bu_exception", bu_exception, '0);
    // JALR with an odd operand sum
    op_a     = rand_bits(32);
    op_b     = rand_bits(32);
    op_b[0]  = ~op_a[0];
    id_instr = 32'h0000_80e7;
    advance_cycle();
    check_pc("bu_nxt_pc", bu_nxt_pc, (op_a + op_b) & {{(xlen-1){1'b1}}, 1'b0});
    check_flag("bu_flush", bu_flush, 1'b1);
    check_exc("bu_exception", bu_exception, '0);
    idle_cycle();
    // Odd target from an odd PC
    run_branch(f3_beq, 32'h0000_1105, 32'h55, 32'h55, 13'h020);
  endtask

  task test_fence_bubble;
    id_pc     = 32'h0000_3400;
    id_instr  = instr_fence_i;
    id_bubble = 1'b0;
    advance_cycle();
    check_flag("bu_flush", bu_flush, 1'b1);
    check_flag("bu_cacheflush", bu_cacheflush, 1'b1);
    check_pc("bu_nxt_pc", bu_nxt_pc, 32'h0000_3404);
    idle_cycle();
    // Bubbled taken branch at an odd PC
    id_pc     = 32'h0000_3501;
    id_instr  = enc_b(f3_beq, 13'h040);
    op_a      = 32'h5;
    op_b      = 32'h5;
    id_bubble = 1'b1;
    advance_cycle();
    check_pc("bu_nxt_pc", bu_nxt_pc, 32'h0000_3505);
    check_flag("bu_flush", bu_flush, 1'b0);
    check_flag("bu_cacheflush", bu_cacheflush, 1'b0);
    check_exc("bu_exception", bu_exception, '0);
  endtask

  task test_exceptions;
    id_bubble    = 1'b1;
    id_exception = 16'h0a50;
    advance_cycle();
    check_exc("bu_exception", bu_exception, 16'h0a50);
    // Held for two stalled cycles
    ex_stall     = 1'b1;
    id_exception = 16'h5a00;
    advance_cycle();
    check_exc("bu_exception", bu_exception, 16'h0a50);
    advance_cycle();
    check_exc("bu_exception", bu_exception, 16'h0a50);
    ex_stall = 1'b0;
    st_flush = 1'b1;
    advance_cycle();
    check_exc("bu_exception", bu_exception, '0);
    st_flush = 1'b0;
    advance_cycle();
    check_exc("bu_exception", bu_exception, 16'h5a00);
    pipe_exception = 1'b1;
    advance_cycle();
    check_exc("bu_exception", bu_exception, '0);
    pipe_exception = 1'b0;
    idle_cycle();
  endtask

  task automatic test_debug;
    logic [xlen-1:0] dbg_pc;
    logic [xlen-1:0] rd;
    int              cycles;
    dbg_pc    = 32'h0000_8a40;
    id_pc     = 32'h0000_2000;
    id_bubble = 1'b1;
    wb_transfer(1'b1, 2'd1, 32'h1, rd);
    wb_transfer(1'b1, 2'd0, dbg_pc, rd);
    cycles = 0;
    while (bu_nxt_pc !== dbg_pc) begin
      if (cycles == pc_timeout) begin
        $display("timeout: debug PC write never showed on bu_nxt_pc");
        abort_run();
      end
      cycles++;
      @(negedge clk);
    end
    check_flag("bu_flush", bu_flush, 1'b1);
    // Override holds across a jump and a taken branch
    id_bubble = 1'b0;
    id_instr  = 32'h0000_80e7;
    op_a      = 32'h0000_4000;
    op_b      = 32'h10;
    advance_cycle();
    check_pc("bu_nxt_pc", bu_nxt_pc, dbg_pc);
    check_flag("bu_flush", bu_flush, 1'b0);
    id_instr = enc_b(f3_bne, 13'h080);
    op_b     = 32'h20;
    advance_cycle();
    check_pc("bu_nxt_pc", bu_nxt_pc, dbg_pc);
    check_flag("bu_flush", bu_flush, 1'b0);
    check_flag("bu_bp_btaken", bu_bp_btaken, 1'b0);
    id_bubble = 1'b1;
    wb_transfer(1'b0, 2'd0, '0, rd);
    check_word("wb_dat_o word 0", rd, dbg_pc);
    wb_transfer(1'b0, 2'd2, '0, rd);
    check_word("wb_dat_o word 2", rd, xlen'(model_miss));
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    rstn           = 1'b0;
    id_pc          = '0;
    id_instr       = 32'h0000_0013;
    id_bubble      = 1'b1;
    op_a           = '0;
    op_b           = '0;
    id_exception   = '0;
    pipe_exception = 1'b0;
    ex_stall       = 1'b0;
    st_flush       = 1'b0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = 2'd0;
    wb_dat_i       = '0;
    lfsr           = 16'd5909;
    model_hist     = '0;
    model_miss     = 0;
    // Every entry weakly not-taken
    for (int i = 0; i < (1 << bht_idx_bits); i++) begin
      model_bht[i] = 2'b01;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    test_reset();
    idle_cycle();
    test_branches();
    test_jumps();
    test_fence_bubble();
    test_exceptions();
    test_debug();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== rv_branch.f ====
hw/rv_branch_pkg.sv
hw/rv_branch_predictor.sv
hw/rv_branch_unit.sv
hw/rv_branch_dbg_wb.sv
hw/rv_branch_top.sv
bench/rv_branch_tb.sv

// ==== Makefile ====
# Verilator build and run for the rv_branch slice

TOOL  = verilator
FLAGS = --binary --assert -j 0
TOP   = rv_branch_tb
FLIST = rv_branch.f
OBJ   = obj_dir

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ)
